// File: all.f
design/ao_periph_pkg.sv
design/obi_to_reg.sv
design/reg_demux.sv
design/soc_ctrl.sv
design/power_manager.sv
design/ao_timer.sv
design/pad_attribute.sv
design/ao_periph_subsystem.sv
tb/tb_ao_periph.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ao_periph
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_ao_periph.sv
/*
 * Testbench for the always-on peripheral subsystem
 * Table-driven OBI accesses, port checks and power sequences
 */
`default_nettype none

module tb_ao_periph;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 8;
  localparam int          NUM_PAD      = 4;
  localparam int unsigned SEED         = 69413;
  localparam int          GNT_LIMIT    = 8;
  localparam int          RVALID_LIMIT = 8;
  localparam int          WAIT_TOL     = 4;
  localparam int          POWER_SEQS   = 2;

  localparam int unsigned W_SOC = ao_periph_pkg::SOC_CTRL_IDX;
  localparam int unsigned W_PM  = ao_periph_pkg::POWER_MANAGER_IDX;
  localparam int unsigned W_TMR = ao_periph_pkg::TIMER_IDX;
  localparam int unsigned W_PAD = ao_periph_pkg::PAD_ATTRIBUTE_IDX;

  typedef logic [NUM_PAD-1:0][15:0] pads_t;
  typedef enum int {OP_WRITE, OP_READ, OP_STATE, OP_DRIVE, OP_WAIT, OP_CHECK} op_e;
  typedef enum int {
    SIG_NONE, SIG_IRQ, SIG_SWITCH, SIG_RSTN, SIG_EXIT_VALID,
    SIG_EXIT_VALUE, SIG_PADS, SIG_BOOT, SIG_SLEEP
  } sig_e;

  typedef struct {
    string       name;
    op_e         op;
    sig_e        sig;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    logic [31:0] exp;
    pads_t       pads;
  } entry_t;

  logic                     clk;
  logic                     arst_n;
  ao_periph_pkg::obi_req_t  slave_req;
  ao_periph_pkg::obi_resp_t slave_resp;
  logic                     boot_select;
  logic                     execute_from_flash;
  logic                     exit_valid;
  logic [31:0]              exit_value;
  logic                     core_sleep;
  logic                     pg_switch;
  logic                     cpu_rst_n;
  logic                     timer_irq;
  pads_t                    pad_attributes;

  entry_t      table_q[$];
  pads_t       pad_model;
  logic        test_ok;
  int          pass_cnt;
  int          fail_cnt;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;

  ao_periph_subsystem #(
    .NUM_PAD (NUM_PAD)
  ) u_dut (
    .clk_i                            (clk),
    .arst_n_i                         (arst_n),
    .slave_req_i                      (slave_req),
    .slave_resp_o                     (slave_resp),
    .boot_select_i                    (boot_select),
    .execute_from_flash_i             (execute_from_flash),
    .exit_valid_o                     (exit_valid),
    .exit_value_o                     (exit_value),
    .core_sleep_i                     (core_sleep),
    .cpu_subsystem_powergate_switch_o (pg_switch),
    .cpu_subsystem_rst_no             (cpu_rst_n),
    .timer_irq_o                      (timer_irq),
    .pad_attributes_o                 (pad_attributes)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] reg_addr(input int unsigned win, input logic [11:0] ofs);
    return ao_periph_pkg::AO_BASE | {16'h0, 4'(win), ofs};
  endfunction

  function automatic void add_entry(input string name, input op_e op, input sig_e sig,
                                    input logic [31:0] addr, input logic [31:0] data,
                                    input logic [3:0] be, input logic [31:0] exp);
    entry_t e;
    e.name = name;
    e.op   = op;
    e.sig  = sig;
    e.addr = addr;
    e.data = data;
    e.be   = be;
    e.exp  = exp;
    // Pad ports are expected to match the model at this point of the table
    e.pads = pad_model;
    table_q.push_back(e);
  endfunction

  function automatic void add_write(input string name, input logic [31:0] addr,
                                    input logic [31:0] data, input logic [3:0] be);
    add_entry(name, OP_WRITE, SIG_NONE, addr, data, be, 32'h0);
  endfunction

  function automatic void add_read(input string name, input logic [31:0] addr,
                                   input logic [31:0] exp);
    add_entry(name, OP_READ, SIG_NONE, addr, 32'h0, 4'h0, exp);
  endfunction

  function automatic void add_state(input string name, input ao_periph_pkg::pm_state_e st);
    add_entry(name, OP_STATE, SIG_NONE, reg_addr(W_PM, ao_periph_pkg::PM_STATUS_OFS),
              32'h0, 4'h0, {30'h0, st});
  endfunction

  function automatic void add_check(input string name, input sig_e sig,
                                    input logic [31:0] exp, input int delay);
    add_entry(name, OP_CHECK, sig, 32'h0, 32'(delay), 4'h0, exp);
  endfunction

  function automatic void add_wait(input string name, input sig_e sig, input logic level,
                                   input int cycles);
    add_entry(name, OP_WAIT, sig, 32'h0, 32'(cycles), 4'h0, {31'h0, level});
  endfunction

  function automatic void add_drive(input string name, input sig_e sig,
                                    input logic [31:0] val);
    add_entry(name, OP_DRIVE, sig, 32'h0, val, 4'h0, 32'h0);
  endfunction

  function automatic void build_table();
    logic [31:0] v;
    logic [31:0] exit_val;
    logic [31:0] t_ctrl;
    logic [31:0] t_cmp;
    logic [31:0] t_count;
    logic [31:0] pm_ctrl;
    int          p;
    int          c;
    int          d;
    t_ctrl   = reg_addr(W_TMR, ao_periph_pkg::TMR_CTRL_OFS);
    t_cmp    = reg_addr(W_TMR, ao_periph_pkg::TMR_CMP_OFS);
    t_count  = reg_addr(W_TMR, ao_periph_pkg::TMR_COUNT_OFS);
    pm_ctrl  = reg_addr(W_PM, ao_periph_pkg::PM_CTRL_OFS);
    add_check("rst switch", SIG_SWITCH, 32'h1, 0);
    add_check("rst cpu reset", SIG_RSTN, 32'h1, 0);
    add_check("rst irq", SIG_IRQ, 32'h0, 0);
    add_check("rst exit valid", SIG_EXIT_VALID, 32'h0, 0);
    add_check("rst exit value", SIG_EXIT_VALUE, 32'h0, 0);
    add_check("rst pads", SIG_PADS, 32'h0, 0);
    add_state("rst pm state", ao_periph_pkg::ACTIVE);

    // Bit 0 is boot select and bit 1 flash execution
    add_drive("strap boot", SIG_BOOT, 32'h1);
    add_read("boot status 1", reg_addr(W_SOC, ao_periph_pkg::SOC_BOOT_STATUS_OFS), 32'h1);
    add_drive("strap flash", SIG_BOOT, 32'h2);
    add_read("boot status 2", reg_addr(W_SOC, ao_periph_pkg::SOC_BOOT_STATUS_OFS), 32'h2);
    exit_val = $urandom();
    add_write("exit value wr", reg_addr(W_SOC, ao_periph_pkg::SOC_EXIT_VALUE_OFS),
              exit_val, 4'hf);
    add_check("exit value port", SIG_EXIT_VALUE, exit_val, 0);
    add_read("exit value rd", reg_addr(W_SOC, ao_periph_pkg::SOC_EXIT_VALUE_OFS), exit_val);
    add_check("exit valid low", SIG_EXIT_VALID, 32'h0, 0);
    add_write("exit valid wr", reg_addr(W_SOC, ao_periph_pkg::SOC_EXIT_VALID_OFS),
              32'h1, 4'hf);
    add_check("exit valid port", SIG_EXIT_VALID, 32'h1, 0);

    for (int i = 0; i < NUM_PAD; i++) begin
      v = $urandom();
      pad_model[i] = v[15:0];
      add_write($sformatf("pad%0d wr", i), reg_addr(W_PAD, 12'(4 * i)), v, 4'hf);
    end
    for (int i = 0; i < NUM_PAD; i++) begin
      add_read($sformatf("pad%0d rd", i), reg_addr(W_PAD, 12'(4 * i)), {16'h0, pad_model[i]});
    end
    add_check("pads port", SIG_PADS, 32'h0, 0);
    v = $urandom();
    pad_model[1][15:8] = v[15:8];
    add_write("pad1 byte wr", reg_addr(W_PAD, 12'h4), v, 4'b0010);
    add_check("pads byte", SIG_PADS, 32'h0, 0);
    add_read("pad1 byte rd", reg_addr(W_PAD, 12'h4), {16'h0, pad_model[1]});
    add_read("pad beyond rd", reg_addr(W_PAD, 12'(4 * NUM_PAD)), 32'h0);
    add_write("pad beyond wr", reg_addr(W_PAD, 12'(4 * NUM_PAD)), $urandom(), 4'hf);
    add_check("pads beyond", SIG_PADS, 32'h0, 0);

    // Unmapped window 7 shares its low select bits with the pad bank
    add_read("unmapped rd", ao_periph_pkg::AO_BASE | 32'h7000, 32'h0);
    add_write("unmapped wr", ao_periph_pkg::AO_BASE | 32'h7000, $urandom(), 4'hf);
    add_check("unmapped pads", SIG_PADS, 32'h0, 0);
    add_read("outside rd", 32'h1000_3000, 32'h0);
    add_write("outside soc wr", 32'h3000_0004, $urandom(), 4'hf);
    add_check("outside exit value", SIG_EXIT_VALUE, exit_val, 0);
    add_write("outside pad wr", 32'h4000_3000, $urandom(), 4'hf);
    add_check("outside pads", SIG_PADS, 32'h0, 0);

    p = 2;
    c = 10;
    add_write("tmr cfg", t_ctrl, {16'h0, 8'(p), 8'h0}, 4'b0011);
    add_write("tmr cmp", t_cmp, 32'(c), 4'hf);
    add_write("tmr count load", t_count, 32'h0, 4'hf);
    add_read("tmr count rd", t_count, 32'h0);
    add_write("tmr enable", t_ctrl, {16'h0, 8'(p), 8'h1}, 4'b0011);
    add_wait("tmr irq rise", SIG_IRQ, 1'b1, c * (p + 1));
    add_write("tmr cmp high", t_cmp, 32'hffff_0000, 4'hf);
    add_check("tmr irq clear", SIG_IRQ, 32'h0, 1);
    add_write("tmr disable", t_ctrl, 32'h0, 4'b0001);
    add_write("tmr count set", t_count, 32'h55, 4'hf);
    add_read("tmr hold 1", t_count, 32'h55);
    add_read("tmr hold 2", t_count, 32'h55);

    d = 5;
    add_write("pm delay", reg_addr(W_PM, ao_periph_pkg::PM_DELAY_OFS), 32'(d), 4'hf);
    add_write("pm sleep en", pm_ctrl, 32'h1, 4'hf);
    add_drive("core sleep", SIG_SLEEP, 32'h1);
    add_wait("pm rst assert", SIG_RSTN, 1'b0, 1);
    add_wait("pm switch off", SIG_SWITCH, 1'b0, d + 1);
    add_state("pm off", ao_periph_pkg::OFF);
    add_drive("core awake", SIG_SLEEP, 32'h0);
    // Timer irq wakes the domain a few cycles later
    add_write("wake tmr cfg", t_ctrl, 32'h0, 4'b0011);
    add_write("wake tmr cmp", t_cmp, 32'h3, 4'hf);
    add_write("wake tmr count", t_count, 32'h0, 4'hf);
    add_write("wake tmr en", t_ctrl, 32'h1, 4'b0011);
    add_wait("pm switch on", SIG_SWITCH, 1'b1, 5);
    add_wait("pm rst release", SIG_RSTN, 1'b1, d + 1);
    add_state("pm active", ao_periph_pkg::ACTIVE);

    add_write("pm sleep dis", pm_ctrl, 32'h0, 4'hf);
    add_write("tmr off", t_ctrl, 32'h0, 4'b0001);
    add_drive("core sleep idle", SIG_SLEEP, 32'h1);
    add_check("pm switch held", SIG_SWITCH, 32'h1, 8);
    add_check("pm rst held", SIG_RSTN, 32'h1, 0);
    add_state("pm still active", ao_periph_pkg::ACTIVE);
    add_drive("core sleep end", SIG_SLEEP, 32'h0);
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s expected %b actual %b", name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_pads(input string name, input pads_t exp, input pads_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_state(input string name, input ao_periph_pkg::pm_state_e exp,
                             input ao_periph_pkg::pm_state_e act);
    if (act !== exp) begin
      $display("error %s expected %s actual %s", name, exp.name(), act.name());
      test_ok = 1'b0;
    end
  endtask

  function automatic logic port_bit(input sig_e sig);
    case (sig)
      SIG_IRQ:        return timer_irq;
      SIG_SWITCH:     return pg_switch;
      SIG_RSTN:       return cpu_rst_n;
      SIG_EXIT_VALID: return exit_valid;
      default:        return 1'bx;
    endcase
  endfunction

  // Grant is sampled a quarter period after the request and rvalid at falling edges
  task automatic obi_transfer(input string name, input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] be,
                              output logic [31:0] rdata);
    int   waited;
    int   lat;
    logic granted;
    waited = 0;
    lat    = 1;
    rdata  = 32'h0;
    @(negedge clk);
    slave_req.req   = 1'b1;
    slave_req.we    = we;
    slave_req.be    = be;
    slave_req.addr  = addr;
    slave_req.wdata = wdata;
    #(CLK_PERIOD / 4);
    while (!slave_resp.gnt && waited < GNT_LIMIT) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      waited++;
    end
    granted = slave_resp.gnt;
    @(negedge clk);
    slave_req = '0;
    if (!granted) begin
      $display("%s: the bus port gave no grant within %0d cycles", name, GNT_LIMIT);
      test_ok = 1'b0;
    end else begin
      if (waited != 0) begin
        $display("%s: grant came %0d cycles after the request", name, waited);
        test_ok = 1'b0;
      end
      while (!slave_resp.rvalid && lat < RVALID_LIMIT) begin
        @(negedge clk);
        lat++;
      end
      if (!slave_resp.rvalid) begin
        $display("%s: no response from the bus port after the grant", name);
        test_ok = 1'b0;
      end else if (lat != 2) begin
        $display("%s: response came %0d cycles after the grant instead of 2", name, lat);
        test_ok = 1'b0;
      end
      rdata = slave_resp.rdata;
    end
  endtask

  task automatic obi_write(input string name, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] be);
    logic [31:0] unused_rdata;
    obi_transfer(name, 1'b1, addr, wdata, be, unused_rdata);
  endtask

  task automatic obi_read(input string name, input logic [31:0] addr,
                          output logic [31:0] rdata);
    obi_transfer(name, 1'b0, addr, 32'h0, 4'hf, rdata);
  endtask

  task automatic drive_pin(input sig_e sig, input logic [31:0] val);
    @(negedge clk);
    if (sig == SIG_BOOT) begin
      boot_select        = val[0];
      execute_from_flash = val[1];
    end else begin
      core_sleep = val[0];
    end
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0] rdata;
    int          cycles;
    test_ok = 1'b1;
    cycles  = 0;
    case (e.op)
      OP_WRITE: obi_write(e.name, e.addr, e.data, e.be);
      OP_READ: begin
        obi_read(e.name, e.addr, rdata);
        check_word(e.name, e.exp, rdata);
      end
      OP_STATE: begin
        obi_read(e.name, e.addr, rdata);
        check_state(e.name, ao_periph_pkg::pm_state_e'(e.exp[1:0]),
                    ao_periph_pkg::pm_state_e'(rdata[1:0]));
      end
      OP_DRIVE: drive_pin(e.sig, e.data);
      OP_WAIT: begin
        do begin
          @(negedge clk);
          cycles++;
        end while (port_bit(e.sig) !== e.exp[0] && cycles < e.data + WAIT_TOL);
        if (port_bit(e.sig) !== e.exp[0]) begin
          check_bit(e.name, e.exp[0], port_bit(e.sig));
        end else if (cycles + WAIT_TOL < e.data || cycles > e.data + WAIT_TOL) begin
          check_word(e.name, e.data, 32'(cycles));
        end
      end
      default: begin
        repeat (e.data) @(negedge clk);
        if (e.sig == SIG_EXIT_VALUE) begin
          check_word(e.name, e.exp, exit_value);
        end else if (e.sig == SIG_PADS) begin
          check_pads(e.name, e.pads, pad_attributes);
        end else begin
          check_bit(e.name, e.exp[0], port_bit(e.sig));
        end
      end
    endcase
    if (test_ok) begin
      $display("ok %s", e.name);
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
  endtask

  initial begin : watchdog
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout, the run did not finish within %0d cycles", cycle_limit);
    $display("test failed");
    $finish;
  end

  initial begin : main
    void'($urandom(SEED));
    arst_n             = 1'b0;
    slave_req          = '0;
    boot_select        = 1'b0;
    execute_from_flash = 1'b0;
    core_sleep         = 1'b0;
    pad_model          = '0;
    pass_cnt           = 0;
    fail_cnt           = 0;
    build_table();
    cycle_limit = RESET_CYCLES + 40 * table_q.size() + 256 * POWER_SEQS;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    foreach (table_q[i]) begin
      run_entry(table_q[i]);
    end
    $display("passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/ao_periph_subsystem.sv
/*
 * Always-on peripheral subsystem top
 * OBI port, register bus demux, SoC control, power manager, timer and pad bank
 */
`default_nettype none

module ao_periph_subsystem #(
  parameter int unsigned NUM_PAD = 4
) (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  ao_periph_pkg::obi_req_t   slave_req_i,
  output ao_periph_pkg::obi_resp_t  slave_resp_o,
  input  wire                       boot_select_i,
  input  wire                       execute_from_flash_i,
  output logic                      exit_valid_o,
  output logic [31:0]               exit_value_o,
  input  wire                       core_sleep_i,
  output logic                      cpu_subsystem_powergate_switch_o,
  output logic                      cpu_subsystem_rst_no,
  output logic                      timer_irq_o,
  output logic [NUM_PAD-1:0][15:0]  pad_attributes_o
);

  ao_periph_pkg::reg_req_t periph_req;
  ao_periph_pkg::reg_rsp_t periph_rsp;
  ao_periph_pkg::reg_req_t [ao_periph_pkg::NUM_PERIPH-1:0] slv_req;
  ao_periph_pkg::reg_rsp_t [ao_periph_pkg::NUM_PERIPH-1:0] slv_rsp;

  obi_to_reg u_obi_to_reg (
    .clk_i,
    .arst_n_i,
    .slave_req_i,
    .slave_resp_o,
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  reg_demux u_reg_demux (
    .clk_i,
    .arst_n_i,
    .in_req_i  (periph_req),
    .in_rsp_o  (periph_rsp),
    .out_req_o (slv_req),
    .out_rsp_i (slv_rsp)
  );

  soc_ctrl u_soc_ctrl (
    .clk_i,
    .arst_n_i,
    .reg_req_i (slv_req[ao_periph_pkg::SOC_CTRL_IDX]),
    .reg_rsp_o (slv_rsp[ao_periph_pkg::SOC_CTRL_IDX]),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  // Timer irq doubles as the wake source
  power_manager u_power_manager (
    .clk_i,
    .arst_n_i,
    .reg_req_i   (slv_req[ao_periph_pkg::POWER_MANAGER_IDX]),
    .reg_rsp_o   (slv_rsp[ao_periph_pkg::POWER_MANAGER_IDX]),
    .timer_irq_i (timer_irq_o),
    .core_sleep_i,
    .cpu_subsystem_powergate_switch_o,
    .cpu_subsystem_rst_no
  );

  ao_timer u_ao_timer (
    .clk_i,
    .arst_n_i,
    .reg_req_i (slv_req[ao_periph_pkg::TIMER_IDX]),
    .reg_rsp_o (slv_rsp[ao_periph_pkg::TIMER_IDX]),
    .timer_irq_o
  );

  pad_attribute #(
    .NUM_PAD (NUM_PAD)
  ) u_pad_attribute (
    .clk_i,
    .arst_n_i,
    .reg_req_i (slv_req[ao_periph_pkg::PAD_ATTRIBUTE_IDX]),
    .reg_rsp_o (slv_rsp[ao_periph_pkg::PAD_ATTRIBUTE_IDX]),
    .pad_attributes_o
  );

endmodule

`default_nettype wire

// File: design/pad_attribute.sv
/*
 * Pad attribute bank, one 16-bit register per pad
 */
`default_nettype none

module pad_attribute #(
  parameter int unsigned NUM_PAD = 4
) (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic [NUM_PAD-1:0][15:0] pad_attributes_o
);

  logic [9:0] idx;
  logic       in_range;

  // Word index, stride of 4 bytes
  assign idx      = reg_req_i.addr[11:2];
  assign in_range = (32'(idx) < NUM_PAD);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pad_attributes_o <= '0;
    end else if (reg_req_i.valid && reg_req_i.write) begin
      for (int i = 0; i < NUM_PAD; i++) begin
        if (idx == 10'(i)) begin
          pad_attributes_o[i] <= 16'(ao_periph_pkg::apply_wstrb(
              {16'h0, pad_attributes_o[i]}, reg_req_i.wdata, {2'b00, reg_req_i.wstrb[1:0]}));
        end
      end
    end
  end

  assign reg_rsp_o.ready = reg_req_i.valid;
  assign reg_rsp_o.rdata = in_range ? {16'h0, pad_attributes_o[idx]} : 32'h0;

endmodule

`default_nettype wire

// File: design/ao_timer.sv
/*
 * Always-on timer, prescaled 32-bit count with compare interrupt
 */
`default_nettype none

module ao_timer (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                    timer_irq_o
);

  logic        en_q;
  logic [7:0]  prescale_q;
  logic [7:0]  pre_cnt_q;
  logic [31:0] count_q;
  logic [31:0] cmp_q;
  logic [11:0] ofs;
  logic        wr;

  assign ofs = reg_req_i.addr[11:0];
  assign wr  = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q        <= 1'b0;
      prescale_q  <= 8'h0;
      pre_cnt_q   <= 8'h0;
      count_q     <= 32'h0;
      cmp_q       <= 32'h0;
      timer_irq_o <= 1'b0;
    end else begin
      if (en_q) begin
        if (pre_cnt_q == prescale_q) begin
          pre_cnt_q <= 8'h0;
          count_q   <= count_q + 32'd1;
        end else begin
          pre_cnt_q <= pre_cnt_q + 8'd1;
        end
      end
      // Register writes take priority over counting
      if (wr && ofs == ao_periph_pkg::TMR_CTRL_OFS) begin
        if (reg_req_i.wstrb[0]) begin
          en_q <= reg_req_i.wdata[0];
        end
        if (reg_req_i.wstrb[1]) begin
          prescale_q <= reg_req_i.wdata[15:8];
        end
      end
      if (wr && ofs == ao_periph_pkg::TMR_COUNT_OFS) begin
        count_q   <= ao_periph_pkg::apply_wstrb(count_q, reg_req_i.wdata, reg_req_i.wstrb);
        pre_cnt_q <= 8'h0;
      end
      if (wr && ofs == ao_periph_pkg::TMR_CMP_OFS) begin
        cmp_q <= ao_periph_pkg::apply_wstrb(cmp_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      timer_irq_o <= en_q && (count_q >= cmp_q);
    end
  end

  assign reg_rsp_o.ready = reg_req_i.valid;

  always_comb begin
    case (ofs)
      ao_periph_pkg::TMR_CTRL_OFS:  reg_rsp_o.rdata = {16'h0, prescale_q, 7'h0, en_q};
      ao_periph_pkg::TMR_COUNT_OFS: reg_rsp_o.rdata = count_q;
      ao_periph_pkg::TMR_CMP_OFS:   reg_rsp_o.rdata = cmp_q;
      default:                      reg_rsp_o.rdata = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/power_manager.sv
/*
 * Power manager for the CPU domain
 * Gates power and reset while the core sleeps, wakes it on the timer irq
 */
`default_nettype none

module power_manager (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  wire                     timer_irq_i,
  input  wire                     core_sleep_i,
  output logic                    cpu_subsystem_powergate_switch_o,
  output logic                    cpu_subsystem_rst_no
);

  ao_periph_pkg::pm_state_e state_q;
  logic                     sleep_en_q;
  logic [7:0]               delay_q;
  logic [7:0]               cnt_q;
  logic [11:0]              ofs;
  logic                     wr;

  assign ofs = reg_req_i.addr[11:0];
  assign wr  = reg_req_i.valid && reg_req_i.write && reg_req_i.wstrb[0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sleep_en_q <= 1'b0;
      delay_q    <= 8'h0;
    end else if (wr) begin
      if (ofs == ao_periph_pkg::PM_CTRL_OFS) begin
        sleep_en_q <= reg_req_i.wdata[0];
      end
      if (ofs == ao_periph_pkg::PM_DELAY_OFS) begin
        delay_q <= reg_req_i.wdata[7:0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q                          <= ao_periph_pkg::ACTIVE;
      cnt_q                            <= 8'h0;
      cpu_subsystem_powergate_switch_o <= 1'b1;
      cpu_subsystem_rst_no             <= 1'b1;
    end else begin
      case (state_q)
        ao_periph_pkg::ACTIVE: begin
          if (sleep_en_q && core_sleep_i) begin
            state_q              <= ao_periph_pkg::RST_ASSERT;
            cnt_q                <= 8'h0;
            cpu_subsystem_rst_no <= 1'b0;
          end
        end
        ao_periph_pkg::RST_ASSERT: begin
          if (cnt_q == delay_q) begin
            state_q                          <= ao_periph_pkg::OFF;
            cpu_subsystem_powergate_switch_o <= 1'b0;
          end else begin
            cnt_q <= cnt_q + 8'd1;
          end
        end
        ao_periph_pkg::OFF: begin
          if (timer_irq_i) begin
            state_q                          <= ao_periph_pkg::RST_RELEASE;
            cnt_q                            <= 8'h0;
            cpu_subsystem_powergate_switch_o <= 1'b1;
          end
        end
        default: begin
          // Let the supply settle before releasing reset
          if (cnt_q == delay_q) begin
            state_q              <= ao_periph_pkg::ACTIVE;
            cpu_subsystem_rst_no <= 1'b1;
          end else begin
            cnt_q <= cnt_q + 8'd1;
          end
        end
      endcase
    end
  end

  assign reg_rsp_o.ready = reg_req_i.valid;

  always_comb begin
    case (ofs)
      ao_periph_pkg::PM_CTRL_OFS:   reg_rsp_o.rdata = {31'h0, sleep_en_q};
      ao_periph_pkg::PM_DELAY_OFS:  reg_rsp_o.rdata = {24'h0, delay_q};
      ao_periph_pkg::PM_STATUS_OFS: reg_rsp_o.rdata = {30'h0, state_q};
      default:                      reg_rsp_o.rdata = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/soc_ctrl.sv
/*
 * SoC control registers, boot straps and the end-of-run exit flag and value
 */
`default_nettype none

module soc_ctrl (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  wire                     boot_select_i,
  input  wire                     execute_from_flash_i,
  output logic                    exit_valid_o,
  output logic [31:0]             exit_value_o
);

  logic [11:0] ofs;
  logic        wr;

  assign ofs = reg_req_i.addr[11:0];
  assign wr  = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= 32'h0;
    end else if (wr) begin
      if (ofs == ao_periph_pkg::SOC_EXIT_VALID_OFS && reg_req_i.wstrb[0]) begin
        exit_valid_o <= reg_req_i.wdata[0];
      end
      if (ofs == ao_periph_pkg::SOC_EXIT_VALUE_OFS) begin
        exit_value_o <= ao_periph_pkg::apply_wstrb(exit_value_o, reg_req_i.wdata,
                                                   reg_req_i.wstrb);
      end
    end
  end

  assign reg_rsp_o.ready = reg_req_i.valid;

  always_comb begin
    case (ofs)
      ao_periph_pkg::SOC_EXIT_VALID_OFS:  reg_rsp_o.rdata = {31'h0, exit_valid_o};
      ao_periph_pkg::SOC_EXIT_VALUE_OFS:  reg_rsp_o.rdata = exit_value_o;
      ao_periph_pkg::SOC_BOOT_STATUS_OFS:
        reg_rsp_o.rdata = {30'h0, execute_from_flash_i, boot_select_i};
      default:                            reg_rsp_o.rdata = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/reg_demux.sv
/*
 * Register bus demux with address decoding
 * Unmapped accesses are answered here with zero data
 */
`default_nettype none

module reg_demux (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  ao_periph_pkg::reg_req_t in_req_i,
  output ao_periph_pkg::reg_rsp_t in_rsp_o,
  output ao_periph_pkg::reg_req_t [ao_periph_pkg::NUM_PERIPH-1:0] out_req_o,
  input  ao_periph_pkg::reg_rsp_t [ao_periph_pkg::NUM_PERIPH-1:0] out_rsp_i
);

  typedef struct packed {
    logic                                 active;
    logic                                 mapped;
    logic [ao_periph_pkg::PERIPH_SEL_W-1:0] sel;
  } route_t;

  route_t route_d;
  route_t route_q;
  route_t route;

  always_comb begin
    route_d.active = 1'b0;
    route_d.mapped = (in_req_i.addr[31:16] == ao_periph_pkg::AO_BASE[31:16]) &&
                     (in_req_i.addr[15:12] < 4'(ao_periph_pkg::NUM_PERIPH));
    route_d.sel    = in_req_i.addr[12 +: ao_periph_pkg::PERIPH_SEL_W];
  end

  // Held route wins once a stalled transfer has started
  assign route = route_q.active ? route_q : route_d;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      route_q <= '0;
    end else if (in_req_i.valid && !in_rsp_o.ready && !route_q.active) begin
      route_q        <= route_d;
      route_q.active <= 1'b1;
    end else if (in_req_i.valid && in_rsp_o.ready) begin
      route_q.active <= 1'b0;
    end
  end

  always_comb begin
    for (int i = 0; i < ao_periph_pkg::NUM_PERIPH; i++) begin
      out_req_o[i]       = in_req_i;
      out_req_o[i].valid = in_req_i.valid && route.mapped &&
                           (route.sel == ao_periph_pkg::PERIPH_SEL_W'(i));
    end
  end

  always_comb begin
    if (route.mapped) begin
      in_rsp_o = out_rsp_i[route.sel];
    end else begin
      in_rsp_o.ready = in_req_i.valid;
      in_rsp_o.rdata = 32'h0;
    end
  end

endmodule

`default_nettype wire

// File: design/obi_to_reg.sv
/*
 * OBI slave to register bus bridge, one transfer in flight
 */
`default_nettype none

module obi_to_reg (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  ao_periph_pkg::obi_req_t   slave_req_i,
  output ao_periph_pkg::obi_resp_t  slave_resp_o,
  output ao_periph_pkg::reg_req_t   reg_req_o,
  input  ao_periph_pkg::reg_rsp_t   reg_rsp_i
);

  typedef enum logic {IDLE, BUSY} state_e;

  state_e                  state_q;
  logic                    rvalid_q;
  logic [31:0]             rdata_q;
  ao_periph_pkg::reg_req_t req_q;
  logic                    gnt;
  logic                    done;

  // No grant while the response of the last transfer is on the port
  assign gnt  = (state_q == IDLE) && slave_req_i.req && !rvalid_q;
  assign done = (state_q == BUSY) && reg_rsp_i.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= done;
      if (gnt) begin
        state_q <= BUSY;
      end else if (done) begin
        state_q <= IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      req_q.valid <= slave_req_i.req;
      req_q.write <= slave_req_i.we;
      req_q.addr  <= slave_req_i.addr;
      req_q.wdata <= slave_req_i.wdata;
      req_q.wstrb <= slave_req_i.be;
    end
    if (done) begin
      rdata_q <= req_q.write ? 32'h0 : reg_rsp_i.rdata;
    end
  end

  always_comb begin
    reg_req_o       = req_q;
    reg_req_o.valid = (state_q == BUSY);
  end

  assign slave_resp_o.gnt    = gnt;
  assign slave_resp_o.rvalid = rvalid_q;
  assign slave_resp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

// File: design/ao_periph_pkg.sv
/*
 * Always-on peripheral subsystem shared definitions
 * Bus structs, address map, register offsets and power states
 */
`default_nettype none

package ao_periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Address map, bits 15:12 pick the peripheral
  localparam int unsigned NUM_PERIPH        = 4;
  localparam int unsigned PERIPH_SEL_W      = 2;
  localparam int unsigned SOC_CTRL_IDX      = 0;
  localparam int unsigned POWER_MANAGER_IDX = 1;
  localparam int unsigned TIMER_IDX         = 2;
  localparam int unsigned PAD_ATTRIBUTE_IDX = 3;
  localparam logic [31:0] AO_BASE           = 32'h2000_0000;

  localparam logic [11:0] SOC_EXIT_VALID_OFS  = 12'h000;
  localparam logic [11:0] SOC_EXIT_VALUE_OFS  = 12'h004;
  localparam logic [11:0] SOC_BOOT_STATUS_OFS = 12'h008;

  localparam logic [11:0] PM_CTRL_OFS   = 12'h000;
  localparam logic [11:0] PM_DELAY_OFS  = 12'h004;
  localparam logic [11:0] PM_STATUS_OFS = 12'h008;

  localparam logic [11:0] TMR_CTRL_OFS  = 12'h000;
  localparam logic [11:0] TMR_COUNT_OFS = 12'h004;
  localparam logic [11:0] TMR_CMP_OFS   = 12'h008;

  typedef enum logic [1:0] {
    ACTIVE      = 2'd0,
    RST_ASSERT  = 2'd1,
    OFF         = 2'd2,
    RST_RELEASE = 2'd3
  } pm_state_e;

  // Byte-wise merge of write data into a register
  function automatic logic [31:0] apply_wstrb(input logic [31:0] old_val,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  wstrb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire
